// File: src/shooter_pkg.sv
`default_nettype none

package shooter_pkg;

	typedef logic [3:0] heading_t;   // 16 steps of 22.5 degrees
	typedef logic [8:0] dist_t;      // Radial distance from the ship
	typedef logic [3:0] points_t;
	typedef logic [19:0] bcd_score_t;

	typedef enum logic [1:0] {
		WPN_SPREAD,   // Five bullets
		WPN_TRIPLE,   // Three bullets
		WPN_CANNON    // One heavy bullet
	} weapon_t;

	typedef enum logic [1:0] {
		EN_BRUTE,
		EN_RAIDER,
		EN_DART,
		EN_TITAN
	} enemy_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FIRE,
		ST_SPAWN,
		ST_MOVE,
		ST_SWEEP,
		ST_DONE
	} step_state_t;

	localparam int SCORE_DIGITS = 5;

	// Indexed by weapon_t
	localparam logic [3:0] BULLET_SPEED [3] = '{4'd7, 4'd5, 4'd4};
	localparam logic [3:0] WEAPON_DAMAGE [3] = '{4'd2, 4'd3, 4'd9};

	// Indexed by enemy_t
	localparam logic [3:0] ENEMY_SPEED [4] = '{4'd3, 4'd4, 4'd5, 4'd1};
	localparam logic [3:0] ENEMY_HEALTH [4] = '{4'd6, 4'd3, 4'd2, 4'd15};
	localparam points_t ENEMY_POINTS [4] = '{4'd6, 4'd3, 4'd2, 4'd15};

	localparam dist_t RANGE_AXIS = 9'd240;   // Headings divisible by 4
	localparam dist_t RANGE_DIAG = 9'd340;   // Remaining even headings
	localparam dist_t RANGE_SKEW = 9'd260;   // Odd headings
	localparam dist_t BREACH_DIST = 9'd15;

	localparam logic [15:0] SPAWN_SEED = 16'hace1;

	// Edge of the field along a heading
	function automatic dist_t range_of(heading_t h);
		if (h[1:0] == 2'b00)
			return RANGE_AXIS;
		else if (!h[0])
			return RANGE_DIAG;
		else
			return RANGE_SKEW;
	endfunction

endpackage

`default_nettype wire

// File: src/pilot_controls.sv
`timescale 1ns/1ns
`default_nettype none

module pilot_controls
	import shooter_pkg::*;
(
	input  logic     CLK,
	input  logic     RESET,
	input  logic     fire,            // Active low, asynchronous
	input  logic     rotate_cw,
	input  logic     rotate_ccw,
	input  logic     weapon_switch,
	input  logic     fire_take,       // Pending shot consumed by the step
	output heading_t heading,
	output weapon_t  weapon,
	output logic     fire_pending
);

	logic [3:0] sync_a;      // Bit order is fire, cw, ccw, switch from bit 0
	logic [3:0] sync_b;
	logic [3:0] sync_prev;   // Last synchronized level for edge detection
	logic [3:0] press;

	always_ff @(posedge CLK) begin
		if (RESET) begin
			sync_a <= '1;          // Buttons idle high
			sync_b <= '1;
			sync_prev <= '1;
		end else begin
			sync_a <= {weapon_switch, rotate_ccw, rotate_cw, fire};
			sync_b <= sync_a;
			sync_prev <= sync_b;
		end
	end

	assign press = sync_prev & ~sync_b;   // High to low

	function automatic weapon_t next_weapon(weapon_t w);
		case (w)
			WPN_SPREAD: return WPN_TRIPLE;
			WPN_TRIPLE: return WPN_CANNON;
			default:    return WPN_SPREAD;
		endcase
	endfunction

	always_ff @(posedge CLK) begin
		if (RESET) begin
			heading <= '0;
			weapon <= WPN_SPREAD;
			fire_pending <= 1'b0;
		end else begin
			// Clockwise lowers the heading and both at once cancel
			heading <= heading + heading_t'(press[2]) - heading_t'(press[1]);
			if (press[3])
				weapon <= next_weapon(weapon);
			if (press[0])
				fire_pending <= 1'b1;   // A new press outranks the take
			else if (fire_take)
				fire_pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: src/step_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module step_sequencer
	import shooter_pkg::*;
#(
	parameter int TICK_CYCLES = 64,
	parameter int BULLET_SLOTS = 20
) (
	input  logic                            CLK,
	input  logic                            RESET,
	input  logic                            fire_pending,
	output logic                            fire_take,
	output logic                            spawn_en,
	output logic                            move_en,
	output logic                            sweep_en,
	output logic [$clog2(BULLET_SLOTS)-1:0] sweep_slot,
	output logic                            step_done
);

	localparam int TICK_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
	localparam int SLOT_W = $clog2(BULLET_SLOTS);

	step_state_t       state;
	logic [TICK_W-1:0] tick_cnt;
	logic              tick;

	assign tick = (tick_cnt == TICK_W'(TICK_CYCLES - 1));

	// Free running game tick divider
	always_ff @(posedge CLK) begin
		if (RESET)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			state <= ST_IDLE;
			sweep_slot <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (tick)
						state <= ST_FIRE;
				end
				ST_FIRE:  state <= ST_SPAWN;
				ST_SPAWN: state <= ST_MOVE;
				ST_MOVE: begin
					state <= ST_SWEEP;
					sweep_slot <= '0;
				end
				ST_SWEEP: begin
					if (sweep_slot == SLOT_W'(BULLET_SLOTS - 1))
						state <= ST_DONE;   // Last slot probed
					else
						sweep_slot <= sweep_slot + 1'b1;
				end
				ST_DONE:  state <= ST_IDLE;
				default:  state <= ST_IDLE;
			endcase
		end
	end

	assign fire_take = (state == ST_FIRE) && fire_pending;
	assign spawn_en = (state == ST_SPAWN);
	assign move_en = (state == ST_MOVE);
	assign sweep_en = (state == ST_SWEEP);
	assign step_done = (state == ST_DONE);

	// A step must finish before the next tick
	a_tick_idle: assert property (@(posedge CLK) disable iff (RESET)
		tick |-> state == ST_IDLE)
		else $error("Game tick arrived during a step");

	a_tick_len: assert property (@(posedge CLK) TICK_CYCLES > BULLET_SLOTS + 4)
		else $error("TICK_CYCLES too short for one step");

endmodule

`default_nettype wire

// File: src/bullet_pool.sv
`timescale 1ns/1ns
`default_nettype none

module bullet_pool
	import shooter_pkg::*;
#(
	parameter int BULLET_SLOTS = 20
) (
	input  logic                            CLK,
	input  logic                            RESET,
	input  logic                            fire_take,
	input  weapon_t                         weapon,
	input  heading_t                        heading,
	input  logic                            move_en,
	input  logic                            sweep_en,
	input  logic [$clog2(BULLET_SLOTS)-1:0] sweep_slot,
	input  logic                            hit,
	output logic                            probe_valid,
	output heading_t                        probe_heading,
	output dist_t                           probe_dist,
	output weapon_t                         probe_weapon
);

	// Spread offsets whose tail also serves triple and cannon
	localparam heading_t SHOT_OFS [5] = '{4'd2, 4'd14, 4'd1, 4'd15, 4'd0};

	logic [BULLET_SLOTS-1:0] live;
	heading_t                b_head [BULLET_SLOTS];
	dist_t                   b_dist [BULLET_SLOTS];
	weapon_t                 b_wpn [BULLET_SLOTS];
	logic [BULLET_SLOTS-1:0] fill;                    // Slot takes a new bullet
	heading_t                fill_head [BULLET_SLOTS];

	function automatic logic [2:0] first_shot(weapon_t w);
		case (w)
			WPN_SPREAD: return 3'd0;
			WPN_TRIPLE: return 3'd2;
			default:    return 3'd4;
		endcase
	endfunction

	// Hand out the shots to free slots starting at the lowest
	always_comb begin
		logic [2:0] k;
		k = first_shot(weapon);
		for (int i = 0; i < BULLET_SLOTS; i++) begin
			fill[i] = 1'b0;
			fill_head[i] = heading;
			if (!live[i] && k < 3'd5) begin
				fill[i] = 1'b1;
				fill_head[i] = heading + SHOT_OFS[k];
				k = k + 3'd1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (RESET) begin
			live <= '0;
		end else begin
			for (int i = 0; i < BULLET_SLOTS; i++) begin
				if (fire_take && fill[i])
					live[i] <= 1'b1;
				else if (move_en && live[i] && b_dist[i] >= range_of(b_head[i]))
					live[i] <= 1'b0;   // Left the field
			end
			if (hit)
				live[sweep_slot] <= 1'b0;   // Bullet spent on an enemy
		end
	end

	always_ff @(posedge CLK) begin
		for (int i = 0; i < BULLET_SLOTS; i++) begin
			if (fire_take && fill[i]) begin
				b_head[i] <= fill_head[i];
				b_dist[i] <= '0;
				b_wpn[i] <= weapon;
			end else if (move_en && live[i]) begin
				b_dist[i] <= b_dist[i] + dist_t'(BULLET_SPEED[b_wpn[i]]);
			end
		end
	end

	assign probe_valid = sweep_en && live[sweep_slot];
	assign probe_heading = b_head[sweep_slot];
	assign probe_dist = b_dist[sweep_slot];
	assign probe_weapon = b_wpn[sweep_slot];

	// Enemy side may only answer a live probe
	a_hit_probe: assert property (@(posedge CLK) disable iff (RESET)
		hit |-> probe_valid)
		else $error("Hit without a valid probe");

endmodule

`default_nettype wire

// File: src/enemy_pool.sv
`timescale 1ns/1ns
`default_nettype none

module enemy_pool
	import shooter_pkg::*;
#(
	parameter int ENEMY_SLOTS = 8
) (
	input  logic     CLK,
	input  logic     RESET,
	input  logic     spawn_en,
	input  logic     move_en,
	input  logic     probe_valid,
	input  heading_t probe_heading,
	input  dist_t    probe_dist,
	input  weapon_t  probe_weapon,
	output logic     hit,
	output logic     kill,
	output enemy_t   kill_type
);

	localparam int IDX_W = (ENEMY_SLOTS > 1) ? $clog2(ENEMY_SLOTS) : 1;

	logic [ENEMY_SLOTS-1:0] live;
	enemy_t                 e_type [ENEMY_SLOTS];
	heading_t               e_head [ENEMY_SLOTS];
	dist_t                  e_dist [ENEMY_SLOTS];
	logic [3:0]             e_health [ENEMY_SLOTS];
	logic [15:0]            lfsr;         // Spawn generator
	logic                   free_found;
	logic [IDX_W-1:0]       free_idx;
	logic [IDX_W-1:0]       hit_idx;
	logic [3:0]             damage;
	heading_t               spawn_head;
	enemy_t                 spawn_type;

	// Scan from the top so the lowest matching slot wins
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		free_found = 1'b0;
		free_idx = '0;
		for (int i = ENEMY_SLOTS - 1; i >= 0; i--) begin
			if (probe_valid && live[i] && e_head[i] == probe_heading &&
					e_dist[i] <= probe_dist) begin
				hit = 1'b1;
				hit_idx = IDX_W'(i);
			end
			if (!live[i]) begin
				free_found = 1'b1;
				free_idx = IDX_W'(i);
			end
		end
	end

	assign damage = WEAPON_DAMAGE[probe_weapon];
	assign kill = hit && (damage >= e_health[hit_idx]);
	assign kill_type = e_type[hit_idx];

	assign spawn_head = lfsr[3:0];
	assign spawn_type = enemy_t'(lfsr[5:4]);

	always_ff @(posedge CLK) begin
		if (RESET) begin
			live <= '0;
			lfsr <= SPAWN_SEED;
		end else begin
			if (spawn_en)
				lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			for (int i = 0; i < ENEMY_SLOTS; i++) begin
				if (spawn_en && free_found && free_idx == IDX_W'(i))
					live[i] <= 1'b1;
				else if (move_en && live[i] && e_dist[i] < BREACH_DIST)
					live[i] <= 1'b0;   // Reached the ship
				else if (kill && hit_idx == IDX_W'(i))
					live[i] <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		for (int i = 0; i < ENEMY_SLOTS; i++) begin
			if (spawn_en && free_found && free_idx == IDX_W'(i)) begin
				e_type[i] <= spawn_type;
				e_head[i] <= spawn_head;
				e_dist[i] <= range_of(spawn_head);   // Appears at the field edge
				e_health[i] <= ENEMY_HEALTH[spawn_type];
			end else if (move_en && live[i] && e_dist[i] >= BREACH_DIST) begin
				e_dist[i] <= e_dist[i] - dist_t'(ENEMY_SPEED[e_type[i]]);
			end else if (hit && !kill && hit_idx == IDX_W'(i)) begin
				e_health[i] <= e_health[i] - damage;
			end
		end
	end

	a_kill_hit: assert property (@(posedge CLK) disable iff (RESET)
		kill |-> hit)
		else $error("Kill without a hit");

endmodule

`default_nettype wire

// File: src/score_keeper.sv
`timescale 1ns/1ns
`default_nettype none

module score_keeper
	import shooter_pkg::*;
(
	input  logic       CLK,
	input  logic       RESET,
	input  logic       fire_take,
	input  logic       kill,
	input  enemy_t     kill_type,
	output bcd_score_t score_bcd
);

	points_t    kill_pts;
	logic [4:0] add_pts;      // Up to 16 if both strobes coincide
	bcd_score_t score_next;

	assign kill_pts = kill ? ENEMY_POINTS[kill_type] : 4'd0;
	assign add_pts = {4'd0, fire_take} + {1'b0, kill_pts};

	// Decimal carry chain where the top carry drops so the score wraps
	always_comb begin
		logic [4:0] carry;
		logic [4:0] sum;
		carry = add_pts;
		for (int d = 0; d < SCORE_DIGITS; d++) begin
			sum = {1'b0, score_bcd[4*d +: 4]} + carry;
			if (sum >= 5'd20) begin
				score_next[4*d +: 4] = 4'(sum - 5'd20);
				carry = 5'd2;
			end else if (sum >= 5'd10) begin
				score_next[4*d +: 4] = 4'(sum - 5'd10);
				carry = 5'd1;
			end else begin
				score_next[4*d +: 4] = sum[3:0];
				carry = 5'd0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (RESET)
			score_bcd <= '0;
		else if (fire_take || kill)
			score_bcd <= score_next;
	end

	for (genvar g = 0; g < SCORE_DIGITS; g++) begin : g_digit_chk
		a_digit: assert property (@(posedge CLK) disable iff (RESET)
			score_bcd[4*g +: 4] <= 4'd9)
			else $error("Score digit %0d out of range", g);
	end

endmodule

`default_nettype wire

// File: src/shooter_top.sv
`timescale 1ns/1ns
`default_nettype none

module shooter_top #(
	parameter int TICK_CYCLES = 64,
	parameter int BULLET_SLOTS = 20,
	parameter int ENEMY_SLOTS = 8
) (
	input  logic                   CLK,
	input  logic                   RESET,
	input  logic                   fire,
	input  logic                   rotate_cw,
	input  logic                   rotate_ccw,
	input  logic                   weapon_switch,
	output shooter_pkg::heading_t  heading,
	output shooter_pkg::weapon_t   weapon,
	output shooter_pkg::bcd_score_t score_bcd,
	output logic                   kill,
	output shooter_pkg::enemy_t    kill_type,
	output logic                   step_done
);

	logic                            fire_pending;
	logic                            fire_take;
	logic                            spawn_en;
	logic                            move_en;
	logic                            sweep_en;
	logic [$clog2(BULLET_SLOTS)-1:0] sweep_slot;
	logic                            probe_valid;   // Bullet under test this cycle
	shooter_pkg::heading_t           probe_heading;
	shooter_pkg::dist_t              probe_dist;
	shooter_pkg::weapon_t            probe_weapon;
	logic                            hit;

	pilot_controls u_pilot_controls (
		.CLK(CLK), .RESET(RESET),
		.fire(fire), .rotate_cw(rotate_cw), .rotate_ccw(rotate_ccw),
		.weapon_switch(weapon_switch), .fire_take(fire_take),
		.heading(heading), .weapon(weapon), .fire_pending(fire_pending)
	);

	step_sequencer #(.TICK_CYCLES(TICK_CYCLES), .BULLET_SLOTS(BULLET_SLOTS)) u_step_sequencer (
		.CLK(CLK), .RESET(RESET), .fire_pending(fire_pending),
		.fire_take(fire_take), .spawn_en(spawn_en), .move_en(move_en),
		.sweep_en(sweep_en), .sweep_slot(sweep_slot), .step_done(step_done)
	);

	bullet_pool #(.BULLET_SLOTS(BULLET_SLOTS)) u_bullet_pool (
		.CLK(CLK), .RESET(RESET),
		.fire_take(fire_take), .weapon(weapon), .heading(heading),
		.move_en(move_en), .sweep_en(sweep_en), .sweep_slot(sweep_slot), .hit(hit),
		.probe_valid(probe_valid), .probe_heading(probe_heading),
		.probe_dist(probe_dist), .probe_weapon(probe_weapon)
	);

	enemy_pool #(.ENEMY_SLOTS(ENEMY_SLOTS)) u_enemy_pool (
		.CLK(CLK), .RESET(RESET),
		.spawn_en(spawn_en), .move_en(move_en),
		.probe_valid(probe_valid), .probe_heading(probe_heading),
		.probe_dist(probe_dist), .probe_weapon(probe_weapon),
		.hit(hit), .kill(kill), .kill_type(kill_type)
	);

	score_keeper u_score_keeper (
		.CLK(CLK), .RESET(RESET),
		.fire_take(fire_take), .kill(kill), .kill_type(kill_type),
		.score_bcd(score_bcd)
	);

endmodule

`default_nettype wire

// File: bench/shooter_tb.sv
`timescale 1ns/1ns
`default_nettype none

module shooter_tb
	import shooter_pkg::*;
();

	localparam int TICK_CYCLES = 64;
	localparam int BULLET_SLOTS = 20;
	localparam int ENEMY_SLOTS = 8;
	localparam int STEP_TIMEOUT = 4 * TICK_CYCLES;   // Cycles allowed per step wait
	localparam int KILL_STEP_LIMIT = 500;            // Steps allowed for the long run

	logic       CLK;
	logic       RESET;
	logic       fire;
	logic       rotate_cw;
	logic       rotate_ccw;
	logic       weapon_switch;
	heading_t   heading;
	weapon_t    weapon;
	bcd_score_t score_bcd;
	logic       kill;
	enemy_t     kill_type;
	logic       step_done;

	logic [31:0] rng_state;
	int          fire_count;    // Steps with a fire press
	int          kill_points;   // Points from every kill cycle
	logic        kill_seen;
	int          exp_heading;
	weapon_t     exp_weapon;

	shooter_top #(
		.TICK_CYCLES(TICK_CYCLES),
		.BULLET_SLOTS(BULLET_SLOTS),
		.ENEMY_SLOTS(ENEMY_SLOTS)
	) u_shooter_top (
		.CLK(CLK), .RESET(RESET),
		.fire(fire), .rotate_cw(rotate_cw), .rotate_ccw(rotate_ccw),
		.weapon_switch(weapon_switch),
		.heading(heading), .weapon(weapon), .score_bcd(score_bcd),
		.kill(kill), .kill_type(kill_type), .step_done(step_done)
	);

	always #4 CLK = ~CLK;

	function automatic int unsigned next_random(int unsigned limit);
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return int'(rng_state[31:16]) % limit;   // Upper bits are the better ones
	endfunction

	// Binary score to five decimal digits that wrap after 99999
	function automatic int to_bcd(int value);
		int v;
		int result;
		v = value % 100000;
		result = 0;
		for (int d = 0; d < SCORE_DIGITS; d++) begin
			result = result | ((v % 10) << (4 * d));
			v = v / 10;
		end
		return result;
	endfunction

	function automatic weapon_t weapon_after(weapon_t w);
		case (w)
			WPN_SPREAD: return WPN_TRIPLE;
			WPN_TRIPLE: return WPN_CANNON;
			default:    return WPN_SPREAD;
		endcase
	endfunction

	task automatic check_value(input string what, input int got, input int expected);
		if (got !== expected) begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			$display("ERRORS FOUND");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		$display("ERRORS FOUND");
		$fatal(1, "Timeout");
	endtask

	// Low for 4 cycles and then high for 4 from a falling edge
	task automatic press_button(input int which);
		case (which)
			0: fire = 1'b0;
			1: rotate_cw = 1'b0;
			2: rotate_ccw = 1'b0;
			default: weapon_switch = 1'b0;
		endcase
		repeat (4) @(negedge CLK);
		fire = 1'b1;
		rotate_cw = 1'b1;
		rotate_ccw = 1'b1;
		weapon_switch = 1'b1;
		repeat (4) @(negedge CLK);
	endtask

	task automatic wait_step_done();
		int n;
		n = 0;
		@(negedge CLK);
		while (!step_done) begin
			if (n == STEP_TIMEOUT)
				stop_on_timeout("step_done never pulsed");
			n++;
			@(negedge CLK);
		end
	endtask

	task automatic watch_first_step();
		int n;
		n = 0;
		@(negedge CLK);
		while (!step_done) begin
			check_value("kill before first step", int'(kill), 0);
			if (n == STEP_TIMEOUT)
				stop_on_timeout("first step never finished");
			n++;
			@(negedge CLK);
		end
	endtask

	task automatic rotate(input logic clockwise);
		if (clockwise) begin
			press_button(1);
			exp_heading = (exp_heading + 15) % 16;   // Clockwise lowers the heading
		end else begin
			press_button(2);
			exp_heading = (exp_heading + 1) % 16;
		end
		check_value("heading", int'(heading), exp_heading);
	endtask

	task automatic switch_weapon();
		press_button(3);
		exp_weapon = weapon_after(exp_weapon);
		check_value("weapon", int'(weapon), int'(exp_weapon));
	endtask

	// Step back into idle and queue one shot for the next step
	task automatic fire_next_step();
		@(negedge CLK);
		fire_count++;
		press_button(0);
	endtask

	// Score model and its compare at every step
	always @(negedge CLK) begin
		if (!RESET) begin
			if (kill) begin
				kill_points = kill_points + int'(ENEMY_POINTS[kill_type]);
				kill_seen = 1'b1;
			end
			if (step_done)
				check_value("score_bcd", int'(score_bcd), to_bcd(fire_count + kill_points));
		end
	end

	initial begin
		int n_cw;
		int n_ccw;
		int steps;
		CLK = 1'b0;
		RESET = 1'b1;
		fire = 1'b1;            // Buttons idle high
		rotate_cw = 1'b1;
		rotate_ccw = 1'b1;
		weapon_switch = 1'b1;
		rng_state = 32'h81fa_5886;
		fire_count = 0;
		kill_points = 0;
		kill_seen = 1'b0;
		exp_heading = 0;
		exp_weapon = WPN_SPREAD;
		repeat (2) @(negedge CLK);
		RESET = 1'b0;

		check_value("heading after reset", int'(heading), 0);
		check_value("weapon after reset", int'(weapon), int'(WPN_SPREAD));
		check_value("score after reset", int'(score_bcd), 0);
		check_value("step_done after reset", int'(step_done), 0);
		watch_first_step();

		n_cw = int'(next_random(8)) + 1;
		n_ccw = int'(next_random(8)) + 1;
		while (n_cw > 0 || n_ccw > 0) begin
			if (n_ccw == 0 || (n_cw > 0 && next_random(2) == 0)) begin
				rotate(1'b1);
				n_cw--;
			end else begin
				rotate(1'b0);
				n_ccw--;
			end
		end

		repeat (3) switch_weapon();   // Triple, cannon, back to spread

		for (int s = 0; s < 30; s++) begin
			wait_step_done();
			if (next_random(2) == 0)
				fire_next_step();
		end

		steps = 0;
		while (!kill_seen || fire_count + kill_points <= 100) begin
			if (steps == KILL_STEP_LIMIT)
				stop_on_timeout("no kill or score still under 100 after the long run");
			wait_step_done();
			@(negedge CLK);
			case (next_random(3))
				0: rotate(1'b1);
				1: rotate(1'b0);
				default: ;
			endcase
			if (next_random(4) == 0)
				switch_weapon();
			fire_count++;
			press_button(0);
			steps++;
		end
		wait_step_done();   // Final compare once the last shot is scored
		@(negedge CLK);     // Compare process has checked that step by now

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
src/shooter_pkg.sv
src/pilot_controls.sv
src/step_sequencer.sv
src/bullet_pool.sv
src/enemy_pool.sv
src/score_keeper.sv
src/shooter_top.sv
bench/shooter_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module shooter_tb -Mdir obj_dir -f project.f

./obj_dir/Vshooter_tb > sim.log 2>&1 || true
cat sim.log

if ! grep -qx "NO ERRORS" sim.log; then
	exit 1
fi
exit 0
